//--- common/sched_pkg.sv
`default_nettype none

package sched_pkg;

	localparam int N_SENSORS = 8;
	localparam int PAUSE_CYCLES = 20; // Idle cycles after each transaction

	typedef logic [7:0] byte_t;
	typedef logic [15:0] frame_t; // Command in the upper byte, address in the lower
	typedef logic [2:0] sensor_idx_t;
	typedef logic [N_SENSORS-1:0] sensor_mask_t;
	typedef logic [5:0] resp_t;
	typedef logic [$clog2(PAUSE_CYCLES)-1:0] pause_cnt_t;

	// Command codes as sent by the receiver
	localparam byte_t CMD_STATUS = 8'h31;
	localparam byte_t CMD_TEMP = 8'h32;
	localparam byte_t CMD_HUMID = 8'h33;
	localparam byte_t CMD_TEMP_ON = 8'h34;
	localparam byte_t CMD_HUMID_ON = 8'h35;
	localparam byte_t CMD_TEMP_OFF = 8'h36;
	localparam byte_t CMD_HUMID_OFF = 8'h37;

	localparam byte_t ADDR_BASE = 8'h31; // ASCII '1' is sensor 0

	typedef struct packed {
		byte_t cmd;
		byte_t addr;
	} sensor_req_t;

	typedef struct packed {
		byte_t data;
		resp_t resp;
	} sensor_reply_t;

	typedef struct packed {
		byte_t addr;
		byte_t data;
		resp_t resp;
	} dec_req_t;

	typedef enum logic [1:0] {
		NONE,
		READ,
		READ_AND_CLEAR,
		SET
	} cmd_action_e;

	typedef enum logic [2:0] {
		COMMAND, // Serve the pending frame
		SLOT, // Check one monitoring slot
		RUN, // Transaction in flight
		NEXT // Advance the slot counter
	} seq_state_e;

endpackage

`default_nettype wire

//--- logic/command_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module command_decoder (
	input wire logic clk,
	input wire logic i_rst_n,
	input wire logic i_data_received,
	input wire sched_pkg::frame_t i_data,
	input wire logic i_take,
	output sched_pkg::cmd_action_e o_action,
	output sched_pkg::sensor_idx_t o_sensor,
	output sched_pkg::byte_t o_cmd
);

	sched_pkg::frame_t frame;
	logic pending;
	sched_pkg::byte_t addr_ofs;
	logic addr_ok;

	// A new frame wins over a take in the same cycle
	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			pending <= 1'b0;
		end else if (i_data_received) begin
			pending <= 1'b1;
		end else if (i_take) begin
			pending <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (i_data_received) begin
			frame <= i_data;
		end
	end

	// Addresses below the base wrap to large offsets
	assign addr_ofs = frame[7:0] - sched_pkg::ADDR_BASE;
	assign addr_ok = addr_ofs < sched_pkg::byte_t'(sched_pkg::N_SENSORS);
	assign o_sensor = sched_pkg::sensor_idx_t'(addr_ofs);
	assign o_cmd = frame[15:8];

	always_comb begin
		o_action = sched_pkg::NONE;
		if (pending && addr_ok) begin
			case (o_cmd)
				sched_pkg::CMD_STATUS, sched_pkg::CMD_TEMP, sched_pkg::CMD_HUMID: begin
					o_action = sched_pkg::READ;
				end
				sched_pkg::CMD_TEMP_OFF, sched_pkg::CMD_HUMID_OFF: begin
					o_action = sched_pkg::READ_AND_CLEAR;
				end
				sched_pkg::CMD_TEMP_ON, sched_pkg::CMD_HUMID_ON: begin
					o_action = sched_pkg::SET;
				end
				default: begin
					o_action = sched_pkg::NONE; // Unknown command is dropped
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- logic/monitor_flags.sv
`timescale 1ns/1ns
`default_nettype none

module monitor_flags (
	input wire logic clk,
	input wire logic i_rst_n,
	input wire logic i_set,
	input wire logic i_clear,
	input wire logic i_humid,
	input wire sched_pkg::sensor_idx_t i_sensor,
	output sched_pkg::sensor_mask_t o_temp_on,
	output sched_pkg::sensor_mask_t o_humid_on
);

	logic update;

	assign update = i_set | i_clear;

	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_temp_on <= '0;
		end else if (update && !i_humid) begin
			o_temp_on[i_sensor] <= i_set; // Set wins over clear
		end
	end

	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_humid_on <= '0;
		end else if (update && i_humid) begin
			o_humid_on[i_sensor] <= i_set;
		end
	end

endmodule

`default_nettype wire

//--- scheduler/poll_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

module poll_sequencer (
	input wire logic clk,
	input wire logic i_rst_n,
	input wire sched_pkg::cmd_action_e i_action,
	input wire sched_pkg::sensor_idx_t i_sensor,
	input wire sched_pkg::byte_t i_cmd,
	output logic o_take,
	output logic o_flag_set,
	output logic o_flag_clear,
	output logic o_flag_humid,
	output sched_pkg::sensor_idx_t o_flag_sensor,
	input wire sched_pkg::sensor_mask_t i_temp_on,
	input wire sched_pkg::sensor_mask_t i_humid_on,
	output logic o_start,
	output sched_pkg::sensor_idx_t o_txn_sensor,
	output sched_pkg::sensor_req_t o_txn_req,
	input wire logic i_txn_done
);

	sched_pkg::seq_state_e state;
	sched_pkg::seq_state_e state_nxt;
	sched_pkg::sensor_idx_t slot_sensor;
	logic slot_humid; // Humidity half of the slot
	logic slot_on;
	logic slot_last;
	logic advance;
	logic cmd_run; // Transaction was started by a frame

	assign slot_on = slot_humid ? i_humid_on[slot_sensor] : i_temp_on[slot_sensor];
	assign slot_last = slot_humid &&
		(slot_sensor == sched_pkg::sensor_idx_t'(sched_pkg::N_SENSORS - 1));
	assign o_flag_sensor = i_sensor;
	assign o_flag_humid = (i_cmd == sched_pkg::CMD_HUMID_ON) ||
		(i_cmd == sched_pkg::CMD_HUMID_OFF);

	always_comb begin
		state_nxt = state;
		o_take = 1'b0;
		o_flag_set = 1'b0;
		o_flag_clear = 1'b0;
		o_start = 1'b0;
		advance = 1'b0;
		o_txn_sensor = slot_sensor;
		o_txn_req.cmd = slot_humid ? sched_pkg::CMD_HUMID : sched_pkg::CMD_TEMP;
		o_txn_req.addr = sched_pkg::ADDR_BASE + sched_pkg::byte_t'(slot_sensor);
		case (state)
			sched_pkg::COMMAND: begin
				o_take = 1'b1;
				o_txn_sensor = i_sensor;
				o_txn_req.cmd = i_cmd;
				o_txn_req.addr = sched_pkg::ADDR_BASE + sched_pkg::byte_t'(i_sensor);
				case (i_action)
					sched_pkg::SET: begin
						o_flag_set = 1'b1;
						state_nxt = sched_pkg::SLOT;
					end
					sched_pkg::READ_AND_CLEAR: begin
						o_flag_clear = 1'b1;
						o_start = 1'b1;
						state_nxt = sched_pkg::RUN;
					end
					sched_pkg::READ: begin
						o_start = 1'b1;
						state_nxt = sched_pkg::RUN;
					end
					default: begin
						state_nxt = sched_pkg::SLOT; // Discard, or nothing pending
					end
				endcase
			end
			sched_pkg::SLOT: begin
				if (slot_on) begin
					o_start = 1'b1;
					state_nxt = sched_pkg::RUN;
				end else begin
					advance = 1'b1;
					state_nxt = slot_last ? sched_pkg::COMMAND : sched_pkg::SLOT;
				end
			end
			sched_pkg::RUN: begin
				if (i_txn_done) begin
					state_nxt = sched_pkg::NEXT;
				end
			end
			sched_pkg::NEXT: begin
				if (cmd_run) begin
					state_nxt = sched_pkg::SLOT; // Sweep starts at slot 0
				end else begin
					advance = 1'b1;
					state_nxt = slot_last ? sched_pkg::COMMAND : sched_pkg::SLOT;
				end
			end
			default: begin
				state_nxt = sched_pkg::COMMAND;
			end
		endcase
	end

	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state <= sched_pkg::COMMAND;
			cmd_run <= 1'b0;
			slot_sensor <= '0;
			slot_humid <= 1'b0;
		end else begin
			state <= state_nxt;
			if (state == sched_pkg::COMMAND) begin
				cmd_run <= o_start;
			end else if (state == sched_pkg::NEXT) begin
				cmd_run <= 1'b0;
			end
			// Wraps back to slot 0 after the last slot
			if (advance) begin
				slot_humid <= !slot_humid;
				if (slot_humid) begin
					slot_sensor <= slot_sensor + 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- scheduler/sensor_transaction.sv
`timescale 1ns/1ns
`default_nettype none

module sensor_transaction (
	input wire logic clk,
	input wire logic i_rst_n,
	input wire logic i_start,
	input wire sched_pkg::sensor_idx_t i_sensor,
	input wire sched_pkg::sensor_req_t i_req,
	output logic o_done,
	output sched_pkg::sensor_mask_t o_sensor_en,
	output sched_pkg::sensor_req_t o_sensor_req,
	input wire sched_pkg::sensor_mask_t i_sensor_done,
	input wire sched_pkg::sensor_reply_t [sched_pkg::N_SENSORS-1:0] i_sensor_reply,
	output logic o_dec_en,
	output sched_pkg::dec_req_t o_dec_req,
	input wire logic i_dec_done
);

	typedef enum logic [1:0] {
		IDLE,
		SENSOR, // Waiting for the channel
		DECODE, // Waiting for the decoder
		PAUSE
	} txn_state_e;

	txn_state_e state;
	sched_pkg::sensor_idx_t sensor;
	sched_pkg::sensor_reply_t reply;
	sched_pkg::pause_cnt_t pause_cnt;
	logic take_start;
	logic sensor_hit;
	logic dec_hit;

	assign reply = i_sensor_reply[sensor];
	assign take_start = (state == IDLE) && i_start;
	// Done levels are ignored while the enable pulse is still out
	assign sensor_hit = (state == SENSOR) && i_sensor_done[sensor] && (o_sensor_en == '0);
	assign dec_hit = (state == DECODE) && i_dec_done && !o_dec_en;

	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state <= IDLE;
			o_sensor_en <= '0;
			o_dec_en <= 1'b0;
			o_done <= 1'b0;
			pause_cnt <= '0;
		end else begin
			o_sensor_en <= '0;
			o_dec_en <= 1'b0;
			o_done <= 1'b0;
			case (state)
				IDLE: begin
					if (take_start) begin
						o_sensor_en <= sched_pkg::sensor_mask_t'(1) << i_sensor; // One-hot
						state <= SENSOR;
					end
				end
				SENSOR: begin
					if (sensor_hit) begin
						o_dec_en <= 1'b1;
						state <= DECODE;
					end
				end
				DECODE: begin
					if (dec_hit) begin
						pause_cnt <= '0;
						state <= PAUSE;
					end
				end
				PAUSE: begin
					if (pause_cnt == sched_pkg::pause_cnt_t'(sched_pkg::PAUSE_CYCLES - 1)) begin
						o_done <= 1'b1;
						state <= IDLE;
					end else begin
						pause_cnt <= pause_cnt + 1'b1;
					end
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (take_start) begin
			sensor <= i_sensor;
			o_sensor_req <= i_req;
		end
		if (sensor_hit) begin
			o_dec_req.addr <= o_sensor_req.addr; // Tag reply with its address
			o_dec_req.data <= reply.data;
			o_dec_req.resp <= reply.resp;
		end
	end

endmodule

`default_nettype wire

//--- scheduler/sensor_scheduler.sv
`timescale 1ns/1ns
`default_nettype none

module sensor_scheduler (
	input wire logic clk,
	input wire logic i_rst_n,
	input wire logic i_data_received,
	input wire sched_pkg::frame_t i_data,
	output sched_pkg::sensor_mask_t o_sensor_en,
	output sched_pkg::sensor_req_t o_sensor_req,
	input wire sched_pkg::sensor_mask_t i_sensor_done,
	input wire sched_pkg::sensor_reply_t [sched_pkg::N_SENSORS-1:0] i_sensor_reply,
	output logic o_dec_en,
	output sched_pkg::dec_req_t o_dec_req,
	input wire logic i_dec_done
);

	sched_pkg::cmd_action_e action;
	sched_pkg::sensor_idx_t cmd_sensor;
	sched_pkg::byte_t cmd;
	logic take;
	logic flag_set;
	logic flag_clear;
	logic flag_humid;
	sched_pkg::sensor_idx_t flag_sensor;
	sched_pkg::sensor_mask_t temp_on;
	sched_pkg::sensor_mask_t humid_on;
	logic txn_start;
	sched_pkg::sensor_idx_t txn_sensor;
	sched_pkg::sensor_req_t txn_req;
	logic txn_done;

	command_decoder cmd_dec_i (
		.clk (clk),
		.i_rst_n (i_rst_n),
		.i_data_received (i_data_received),
		.i_data (i_data),
		.i_take (take),
		.o_action (action),
		.o_sensor (cmd_sensor),
		.o_cmd (cmd)
	);

	monitor_flags flags_i (
		.clk (clk),
		.i_rst_n (i_rst_n),
		.i_set (flag_set),
		.i_clear (flag_clear),
		.i_humid (flag_humid),
		.i_sensor (flag_sensor),
		.o_temp_on (temp_on),
		.o_humid_on (humid_on)
	);

	poll_sequencer seq_i (
		.clk (clk),
		.i_rst_n (i_rst_n),
		.i_action (action),
		.i_sensor (cmd_sensor),
		.i_cmd (cmd),
		.o_take (take),
		.o_flag_set (flag_set),
		.o_flag_clear (flag_clear),
		.o_flag_humid (flag_humid),
		.o_flag_sensor (flag_sensor),
		.i_temp_on (temp_on),
		.i_humid_on (humid_on),
		.o_start (txn_start),
		.o_txn_sensor (txn_sensor),
		.o_txn_req (txn_req),
		.i_txn_done (txn_done)
	);

	sensor_transaction txn_i (
		.clk (clk),
		.i_rst_n (i_rst_n),
		.i_start (txn_start),
		.i_sensor (txn_sensor),
		.i_req (txn_req),
		.o_done (txn_done),
		.o_sensor_en (o_sensor_en),
		.o_sensor_req (o_sensor_req),
		.i_sensor_done (i_sensor_done),
		.i_sensor_reply (i_sensor_reply),
		.o_dec_en (o_dec_en),
		.o_dec_req (o_dec_req),
		.i_dec_done (i_dec_done)
	);

endmodule

`default_nettype wire

//--- testbench/tb_sensor_scheduler.sv
`timescale 1ns/1ns
`default_nettype none

module tb_sensor_scheduler;

	localparam int N_RANDOM = 24;
	localparam int N_CMDS = 24 + 2 + 3 + 1 + N_RANDOM + 2 * sched_pkg::N_SENSORS;
	localparam int SWEEP_MAX = 16 * (40 + sched_pkg::PAUSE_CYCLES);
	localparam int TIMEOUT = N_CMDS * 2 * SWEEP_MAX + 1000; // A command may wait two sweeps

	typedef struct packed {
		logic is_cmd; // Read of a frame, a fresh sweep follows it
		sched_pkg::sensor_req_t req;
		sched_pkg::dec_req_t rec;
	} exp_entry_t;

	logic clk = 1'b0;
	logic rst_n;
	logic data_received;
	sched_pkg::frame_t data;
	sched_pkg::sensor_mask_t sensor_en;
	sched_pkg::sensor_req_t sensor_req;
	sched_pkg::sensor_mask_t sensor_done;
	sched_pkg::sensor_reply_t [sched_pkg::N_SENSORS-1:0] sensor_reply;
	logic dec_en;
	sched_pkg::dec_req_t dec_req;
	logic dec_done;

	exp_entry_t exp_q[$];
	sched_pkg::sensor_mask_t temp_m; // Flag model
	sched_pkg::sensor_mask_t humid_m;
	string test_name = "reset";
	int seed = 35511;
	int rec_cnt = 0;
	int mismatch_cnt = 0;
	int fail_cnt = 0;
	int cycle_cnt = 0;

	sensor_scheduler dut_i (
		.clk (clk),
		.i_rst_n (rst_n),
		.i_data_received (data_received),
		.i_data (data),
		.o_sensor_en (sensor_en),
		.o_sensor_req (sensor_req),
		.i_sensor_done (sensor_done),
		.i_sensor_reply (sensor_reply),
		.o_dec_en (dec_en),
		.o_dec_req (dec_req),
		.i_dec_done (dec_done)
	);

	always #2 clk = ~clk;

	always @(posedge clk) begin
		cycle_cnt++;
		if (cycle_cnt > TIMEOUT) begin
			$display("Timeout: the run did not finish within %0d cycles", TIMEOUT);
			print_counts();
			$display("CHECKS FAILED");
			$finish;
		end
	end

	task automatic wait_cycle();
		@(posedge clk);
		#1; // Outputs settled, inputs change here
	endtask

	task automatic print_counts();
		$display("Errors: %0d mismatches, %0d other failures, %0d records checked",
			mismatch_cnt, fail_cnt, rec_cnt);
	endtask

	task automatic report_error(input string msg);
		$display("ERROR in %s: %s", test_name, msg);
		fail_cnt++;
	endtask

	task automatic check_dec(input string name, input sched_pkg::dec_req_t exp,
		input sched_pkg::dec_req_t act);
		if (act !== exp) begin
			$display("MISMATCH %s expected %h actual %h", name, exp, act);
			mismatch_cnt++;
		end
	endtask

	task automatic check_mask(input string name, input sched_pkg::sensor_mask_t exp,
		input sched_pkg::sensor_mask_t act);
		if (act !== exp) begin
			$display("MISMATCH %s expected %h actual %h", name, exp, act);
			mismatch_cnt++;
		end
	endtask

	task automatic check_req(input string name, input sched_pkg::sensor_req_t exp,
		input sched_pkg::sensor_req_t act);
		if (act !== exp) begin
			$display("MISMATCH %s expected %h actual %h", name, exp, act);
			mismatch_cnt++;
		end
	endtask

	function automatic sched_pkg::sensor_reply_t expected_reply(
		input sched_pkg::sensor_idx_t sensor, input sched_pkg::byte_t cmd);
		sched_pkg::sensor_reply_t r;
		r.data = {1'b0, sensor, cmd[3:0]}; // Sensor times 16 plus low nibble
		r.resp = cmd[5:0];
		return r;
	endfunction

	function automatic sched_pkg::sensor_idx_t index_of(input sched_pkg::byte_t addr);
		return sched_pkg::sensor_idx_t'(addr - sched_pkg::ADDR_BASE);
	endfunction

	function automatic sched_pkg::sensor_mask_t sensor_bit(input sched_pkg::byte_t addr);
		sched_pkg::sensor_mask_t m;
		m = '0;
		m[index_of(addr)] = 1'b1;
		return m;
	endfunction

	function automatic exp_entry_t make_entry(input sched_pkg::byte_t addr,
		input sched_pkg::byte_t cmd, input logic is_cmd);
		exp_entry_t e;
		sched_pkg::sensor_reply_t r;
		r = expected_reply(index_of(addr), cmd);
		e.is_cmd = is_cmd;
		e.req.cmd = cmd;
		e.req.addr = addr;
		e.rec.addr = addr;
		e.rec.data = r.data;
		e.rec.resp = r.resp;
		return e;
	endfunction

	// One sweep in slot order with the flags of the model
	function automatic void fill_sweep();
		sched_pkg::byte_t addr;
		for (int s = 0; s < sched_pkg::N_SENSORS; s++) begin
			addr = sched_pkg::ADDR_BASE + sched_pkg::byte_t'(s);
			if (temp_m[s]) begin
				exp_q.push_back(make_entry(addr, sched_pkg::CMD_TEMP, 1'b0));
			end
			if (humid_m[s]) begin
				exp_q.push_back(make_entry(addr, sched_pkg::CMD_HUMID, 1'b0));
			end
		end
	endfunction

	// Returns 0 for a dropped frame, 1 when a record follows, 2 for a flag update only
	function automatic int apply_frame(input sched_pkg::frame_t f);
		sched_pkg::byte_t cmd;
		sched_pkg::byte_t addr;
		int kind;
		cmd = f[15:8];
		addr = f[7:0];
		kind = 0;
		if (addr >= sched_pkg::ADDR_BASE && addr <= sched_pkg::ADDR_BASE + 8'd7) begin
			case (cmd)
				sched_pkg::CMD_STATUS, sched_pkg::CMD_TEMP, sched_pkg::CMD_HUMID: begin
					kind = 1;
				end
				sched_pkg::CMD_TEMP_ON: begin
					temp_m[index_of(addr)] = 1'b1;
					kind = 2;
				end
				sched_pkg::CMD_HUMID_ON: begin
					humid_m[index_of(addr)] = 1'b1;
					kind = 2;
				end
				sched_pkg::CMD_TEMP_OFF: begin
					temp_m[index_of(addr)] = 1'b0;
					kind = 1;
				end
				sched_pkg::CMD_HUMID_OFF: begin
					humid_m[index_of(addr)] = 1'b0;
					kind = 1;
				end
				default: begin
					kind = 0;
				end
			endcase
		end
		if (kind == 1) begin
			exp_q.push_back(make_entry(addr, cmd, 1'b1));
		end
		return kind;
	endfunction

	task automatic wait_record();
		int n;
		n = rec_cnt;
		while (rec_cnt == n) begin
			wait_cycle();
		end
	endtask

	// A frame sent just after a record is taken at the end of the running sweep.
	// A flag update has no record, so the first record of the next sweep shows it was taken
	task automatic send_command(input string name, input sched_pkg::byte_t cmd,
		input sched_pkg::byte_t addr);
		int kind;
		test_name = name;
		if (exp_q.size() != 0 || temp_m != '0 || humid_m != '0) begin
			wait_record();
		end
		wait_cycle();
		data_received = 1'b1;
		data = {cmd, addr};
		kind = apply_frame(data);
		wait_cycle();
		data_received = 1'b0;
		if (kind == 0) begin
			repeat (40) wait_cycle();
		end else begin
			while (exp_q.size() != 0) begin
				wait_cycle();
			end
			if (kind == 2) begin
				wait_record();
			end
		end
	endtask

	// Scoreboard compare process
	initial begin
		exp_entry_t e;
		forever begin
			wait_cycle();
			if (sensor_en != '0) begin
				if (exp_q.size() == 0) begin
					fill_sweep();
				end
				if (exp_q.size() == 0) begin
					report_error("sensor enabled while no read was expected");
				end else begin
					check_mask(test_name, sensor_bit(exp_q[0].rec.addr), sensor_en);
					check_req(test_name, exp_q[0].req, sensor_req);
				end
			end
			if (dec_en) begin
				if (exp_q.size() == 0) begin
					report_error("decoder request while no record was expected");
				end else begin
					e = exp_q.pop_front();
					check_dec(test_name, e.rec, dec_req);
					rec_cnt++;
					if (e.is_cmd) begin
						fill_sweep();
					end
				end
			end
		end
	end

	// Sensor channels, one reply in flight
	initial begin
		sched_pkg::sensor_idx_t s;
		int unsigned delay;
		sensor_done = '0;
		sensor_reply = '0;
		forever begin
			wait_cycle();
			if (sensor_en != '0) begin
				s = '0;
				for (int i = 0; i < sched_pkg::N_SENSORS; i++) begin
					if (sensor_en[i]) begin
						s = sched_pkg::sensor_idx_t'(i);
					end
				end
				delay = 1 + $unsigned($random(seed)) % 12;
				repeat (delay) wait_cycle();
				sensor_reply[s] = expected_reply(s, sensor_req.cmd);
				sensor_done[s] = 1'b1;
				while (!dec_en) begin
					wait_cycle();
				end
				sensor_done[s] = 1'b0;
			end
		end
	end

	// Result decoder
	initial begin
		int unsigned delay;
		dec_done = 1'b0;
		forever begin
			wait_cycle();
			if (dec_en) begin
				delay = 1 + $unsigned($random(seed)) % 6;
				repeat (delay) wait_cycle();
				dec_done = 1'b1;
				wait_cycle();
				dec_done = 1'b0;
			end
		end
	end

	initial begin
		sched_pkg::byte_t rand_cmd[N_RANDOM];
		sched_pkg::byte_t rand_addr[N_RANDOM];
		rst_n = 1'b0;
		data_received = 1'b0;
		data = '0;
		temp_m = '0;
		humid_m = '0;
		// Random frames are drawn before the channel models start drawing delays
		for (int i = 0; i < N_RANDOM; i++) begin
			rand_cmd[i] = sched_pkg::CMD_STATUS +
				sched_pkg::byte_t'($unsigned($random(seed)) % 7);
			rand_addr[i] = sched_pkg::ADDR_BASE +
				sched_pkg::byte_t'($unsigned($random(seed)) % 8);
		end
		repeat (3) @(posedge clk);
		#1;
		rst_n = 1'b1;
		repeat (60) begin
			wait_cycle();
			check_mask("reset_idle", '0, sensor_en);
			if (dec_en) begin
				report_error("decoder enabled with no frame sent");
			end
		end
		for (int a = 0; a < sched_pkg::N_SENSORS; a++) begin
			for (int c = 0; c < 3; c++) begin
				send_command("one_shot", sched_pkg::CMD_STATUS + sched_pkg::byte_t'(c),
					sched_pkg::ADDR_BASE + sched_pkg::byte_t'(a));
			end
		end
		send_command("bad_address", sched_pkg::CMD_TEMP, 8'h39);
		send_command("bad_command", 8'h38, sched_pkg::ADDR_BASE);
		send_command("sweep_on", sched_pkg::CMD_TEMP_ON, sched_pkg::ADDR_BASE + 8'd2);
		send_command("sweep_on", sched_pkg::CMD_TEMP_ON, sched_pkg::ADDR_BASE + 8'd5);
		send_command("sweep_on", sched_pkg::CMD_HUMID_ON, sched_pkg::ADDR_BASE + 8'd5);
		repeat (6) wait_record();
		send_command("sweep_off", sched_pkg::CMD_TEMP_OFF, sched_pkg::ADDR_BASE + 8'd5);
		repeat (6) wait_record();
		for (int i = 0; i < N_RANDOM; i++) begin
			send_command("random", rand_cmd[i], rand_addr[i]);
		end
		for (int s = 0; s < sched_pkg::N_SENSORS; s++) begin
			if (temp_m[s]) begin
				send_command("cleanup", sched_pkg::CMD_TEMP_OFF,
					sched_pkg::ADDR_BASE + sched_pkg::byte_t'(s));
			end
			if (humid_m[s]) begin
				send_command("cleanup", sched_pkg::CMD_HUMID_OFF,
					sched_pkg::ADDR_BASE + sched_pkg::byte_t'(s));
			end
		end
		repeat (60) wait_cycle();
		if (exp_q.size() != 0) begin
			report_error("expected records never arrived");
		end
		print_counts();
		if (mismatch_cnt + fail_cnt == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- filelist.f
common/sched_pkg.sv
logic/command_decoder.sv
logic/monitor_flags.sv
scheduler/poll_sequencer.sv
scheduler/sensor_transaction.sv
scheduler/sensor_scheduler.sv
testbench/tb_sensor_scheduler.sv

//--- run_sim.sh
#!/bin/sh
verilator --binary --timing -f filelist.f --top-module tb_sensor_scheduler -o tb_sim \
	> build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log
grep -q "CHECKS FAILED" sim.log && exit 1 || exit 0
